/* cache_consts.svh */
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// cpu bus widths
`define ADDR_W 32
`define DATA_W 32

// direct-mapped store, one word per line
`define CACHE_LINES 16

// log2 of CACHE_LINES, keep the two in step
`define INDEX_W 4

// pending addresses held by the pacer
`define QUEUE_DEPTH 4

// cycles between read issue slots
`define REQ_PERIOD 10

`endif

/* ahb_pkg.sv */
`default_nettype none

package ahb_pkg;

  `include "cache_consts.svh"

  // byte address as seen on the cpu side
  typedef logic [`ADDR_W-1:0] haddr_t;

  // one bus word
  typedef logic [`DATA_W-1:0] hdata_t;

  // read request from the pacer
  // strobe is a single-cycle issue pulse
  typedef struct packed {
    logic   strobe;
    haddr_t addr;
  } cpu_req_s;

  // response back to the cpu
  // hit low means the word came from memory
  typedef struct packed {
    logic   valid;
    logic   hit;
    hdata_t data;
  } cpu_rsp_s;

endpackage

`default_nettype wire

/* cache_pkg.sv */
`default_nettype none

package cache_pkg;

  `include "cache_consts.svh"

  // line select, address bits just above the byte offset
  typedef logic [`INDEX_W-1:0] index_t;

  // what is left above index and byte offset
  typedef logic [`ADDR_W-`INDEX_W-3:0] tag_t;

  // request after the tag array lookup
  // stored_* are the indexed line's contents at issue time
  typedef struct packed {
    logic            valid;
    tag_t            tag;
    index_t          index;
    tag_t            stored_tag;
    logic            stored_valid;
    ahb_pkg::haddr_t addr;
  } dec_req_s;

  // miss handling
  // wait_mem holds until the memory answers
  // write_line updates the line and returns the word
  typedef enum logic [1:0] {
    idle,
    wait_mem,
    write_line
  } fill_state_e;

endpackage

`default_nettype wire

/* cpu_req_pacer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cpu_req_pacer (
  input  wire logic             cpu_intf,
  input  wire logic             arst_n,
  input  wire ahb_pkg::haddr_t  addr_in,
  input  wire logic             addr_push,
  input  wire logic             busy,
  output logic                  addr_full,
  output ahb_pkg::cpu_req_s     req
);

  localparam int PTR_W = $clog2(`QUEUE_DEPTH);
  localparam int CNT_W = $clog2(`REQ_PERIOD);
  localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(`QUEUE_DEPTH - 1);
  localparam logic [PTR_W:0] DEPTH = (PTR_W + 1)'(`QUEUE_DEPTH);
  localparam logic [CNT_W-1:0] LAST_CYCLE = CNT_W'(`REQ_PERIOD - 1);

  ahb_pkg::haddr_t  addr_q [`QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   fill_cnt;
  logic [CNT_W-1:0] period_cnt;
  logic             wrap;
  logic             push_ok;
  logic             pop;
  logic             strobe_q;
  ahb_pkg::haddr_t  addr_out_q;

  assign wrap      = (period_cnt == LAST_CYCLE);
  assign addr_full = (fill_cnt == DEPTH);

  // push while full is simply lost
  assign push_ok = addr_push && !addr_full;

  // a slot with nothing queued or the cache busy is skipped
  assign pop = wrap && (fill_cnt != '0) && !busy;

  // queue storage
  always_ff @(posedge cpu_intf) begin
    if (push_ok) begin
      addr_q[wr_ptr] <= addr_in;
    end
  end

  // address travels with the strobe
  always_ff @(posedge cpu_intf) begin
    if (pop) begin
      addr_out_q <= addr_q[rd_ptr];
    end
  end

  always_ff @(posedge cpu_intf or negedge arst_n) begin
    if (!arst_n) begin
      period_cnt <= '0;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill_cnt   <= '0;
      strobe_q   <= 1'b0;
    end else begin
      // free-running slot timer
      period_cnt <= wrap ? '0 : period_cnt + 1'b1;
      strobe_q   <= pop;
      if (push_ok) begin
        wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
      end
      // occupancy, push and pop may coincide
      case ({push_ok, pop})
        2'b10:   fill_cnt <= fill_cnt + 1'b1;
        2'b01:   fill_cnt <= fill_cnt - 1'b1;
        default: fill_cnt <= fill_cnt;
      endcase
    end
  end

  assign req = '{strobe: strobe_q, addr: addr_out_q};

endmodule

`default_nettype wire

/* cache_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_decode (
  input  wire logic              cpu_intf,
  input  wire logic              arst_n,
  input  wire ahb_pkg::cpu_req_s req,
  input  wire logic              fill_we,
  input  wire cache_pkg::index_t fill_index,
  input  wire cache_pkg::tag_t   fill_tag,
  output cache_pkg::dec_req_s    dec
);

  cache_pkg::tag_t         tag_mem [`CACHE_LINES];
  logic [`CACHE_LINES-1:0] line_valid;
  cache_pkg::index_t       req_index;
  cache_pkg::tag_t         req_tag;
  logic                    valid_q;
  cache_pkg::tag_t         tag_q;
  cache_pkg::index_t       index_q;
  cache_pkg::tag_t         stored_tag_q;
  logic                    stored_valid_q;
  ahb_pkg::haddr_t         addr_q;

  // byte offset bits [1:0] are ignored, reads are word wide
  assign req_index = req.addr[`INDEX_W+1:2];
  assign req_tag   = req.addr[`ADDR_W-1:`INDEX_W+2];

  // tag store, written only by a line fill
  always_ff @(posedge cpu_intf) begin
    if (fill_we) begin
      tag_mem[fill_index] <= fill_tag;
    end
  end

  // all lines invalid out of reset
  always_ff @(posedge cpu_intf or negedge arst_n) begin
    if (!arst_n) begin
      line_valid <= '0;
    end else if (fill_we) begin
      line_valid[fill_index] <= 1'b1;
    end
  end

  always_ff @(posedge cpu_intf or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req.strobe;
    end
  end

  // lookup result captured with the request
  // no fill can land here, the pacer holds off while busy
  always_ff @(posedge cpu_intf) begin
    if (req.strobe) begin
      tag_q          <= req_tag;
      index_q        <= req_index;
      stored_tag_q   <= tag_mem[req_index];
      stored_valid_q <= line_valid[req_index];
      addr_q         <= req.addr;
    end
  end

  assign dec = '{valid:        valid_q,
                 tag:          tag_q,
                 index:        index_q,
                 stored_tag:   stored_tag_q,
                 stored_valid: stored_valid_q,
                 addr:         addr_q};

endmodule

`default_nettype wire

/* cache_execute.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_execute (
  input  wire logic                cpu_intf,
  input  wire logic                arst_n,
  input  wire cache_pkg::dec_req_s dec,
  input  wire logic                mem_valid,
  input  wire ahb_pkg::hdata_t     mem_rdata,
  output logic                     busy,
  output logic                     mem_req,
  output ahb_pkg::haddr_t          mem_addr,
  output logic                     fill_we,
  output cache_pkg::index_t        fill_index,
  output cache_pkg::tag_t          fill_tag,
  output ahb_pkg::cpu_rsp_s        rsp
);

  cache_pkg::fill_state_e state;
  ahb_pkg::hdata_t        data_mem [`CACHE_LINES];
  ahb_pkg::hdata_t        fill_data;
  logic                   hit;
  logic                   miss;
  logic                   rsp_valid_q;
  logic                   rsp_hit_q;
  ahb_pkg::hdata_t        rsp_data_q;

  // tag match on a valid line
  assign hit  = dec.valid && dec.stored_valid && (dec.tag == dec.stored_tag);
  assign miss = dec.valid && !hit;

  // busy from the miss until the response leaves
  assign busy    = (state != cache_pkg::idle);
  assign fill_we = (state == cache_pkg::write_line);

  always_ff @(posedge cpu_intf or negedge arst_n) begin
    if (!arst_n) begin
      state       <= cache_pkg::idle;
      mem_req     <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      // both are single-cycle pulses
      mem_req     <= 1'b0;
      rsp_valid_q <= 1'b0;
      case (state)
        cache_pkg::idle: begin
          if (hit) begin
            rsp_valid_q <= 1'b1;
          end else if (miss) begin
            mem_req <= 1'b1;
            state   <= cache_pkg::wait_mem;
          end
        end
        cache_pkg::wait_mem: begin
          // one request outstanding, wait as long as it takes
          if (mem_valid) begin
            state <= cache_pkg::write_line;
          end
        end
        cache_pkg::write_line: begin
          // line written this cycle, response goes out with it
          rsp_valid_q <= 1'b1;
          state       <= cache_pkg::idle;
        end
        default: begin
          state <= cache_pkg::idle;
        end
      endcase
    end
  end

  // data path
  always_ff @(posedge cpu_intf) begin
    if ((state == cache_pkg::idle) && hit) begin
      rsp_hit_q  <= 1'b1;
      rsp_data_q <= data_mem[dec.index];
    end
    // remember where the fill goes
    if ((state == cache_pkg::idle) && miss) begin
      mem_addr   <= dec.addr;
      fill_index <= dec.index;
      fill_tag   <= dec.tag;
    end
    if ((state == cache_pkg::wait_mem) && mem_valid) begin
      fill_data <= mem_rdata;
    end
    // fill also forwards the word as a miss response
    if (fill_we) begin
      data_mem[fill_index] <= fill_data;
      rsp_hit_q            <= 1'b0;
      rsp_data_q           <= fill_data;
    end
  end

  assign rsp = '{valid: rsp_valid_q, hit: rsp_hit_q, data: rsp_data_q};

endmodule

`default_nettype wire

/* cache_result.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_result (
  input  wire logic              cpu_intf,
  input  wire logic              arst_n,
  input  wire ahb_pkg::cpu_rsp_s rsp,
  output logic                   rsp_valid,
  output logic                   rsp_hit,
  output ahb_pkg::hdata_t        rsp_data,
  output logic [15:0]            hit_count,
  output logic [15:0]            miss_count
);

  logic [15:0] hit_q;
  logic [15:0] miss_q;
  logic [15:0] hit_next;
  logic [15:0] miss_next;

  // response straight through to the cpu
  assign rsp_valid = rsp.valid;
  assign rsp_hit   = rsp.hit;
  assign rsp_data  = rsp.data;

  // counters stick at all ones
  always_comb begin
    hit_next  = hit_q;
    miss_next = miss_q;
    if (rsp.valid && rsp.hit && (hit_q != '1)) begin
      hit_next = hit_q + 1'b1;
    end
    if (rsp.valid && !rsp.hit && (miss_q != '1)) begin
      miss_next = miss_q + 1'b1;
    end
  end

  always_ff @(posedge cpu_intf or negedge arst_n) begin
    if (!arst_n) begin
      hit_q  <= '0;
      miss_q <= '0;
    end else begin
      hit_q  <= hit_next;
      miss_q <= miss_next;
    end
  end

  // counts already include the response on the bus
  assign hit_count  = hit_next;
  assign miss_count = miss_next;

endmodule

`default_nettype wire

/* cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top (
  input  wire logic            cpu_intf,
  input  wire logic            arst_n,
  // address queue load
  input  wire ahb_pkg::haddr_t addr_in,
  input  wire logic            addr_push,
  output logic                 addr_full,
  // memory port
  output logic                 mem_req,
  output ahb_pkg::haddr_t      mem_addr,
  input  wire logic            mem_valid,
  input  wire ahb_pkg::hdata_t mem_rdata,
  // cpu response and stats
  output logic                 rsp_valid,
  output logic                 rsp_hit,
  output ahb_pkg::hdata_t      rsp_data,
  output logic [15:0]          hit_count,
  output logic [15:0]          miss_count
);

  ahb_pkg::cpu_req_s   req;
  cache_pkg::dec_req_s dec;
  ahb_pkg::cpu_rsp_s   rsp;
  logic                busy;
  logic                fill_we;
  cache_pkg::index_t   fill_index;
  cache_pkg::tag_t     fill_tag;

  // issues one read per slot
  cpu_req_pacer u_pacer (
    .cpu_intf  (cpu_intf),
    .arst_n    (arst_n),
    .addr_in   (addr_in),
    .addr_push (addr_push),
    .busy      (busy),
    .addr_full (addr_full),
    .req       (req)
  );

  // tag lookup, fill updates come back from execute
  cache_decode u_decode (
    .cpu_intf   (cpu_intf),
    .arst_n     (arst_n),
    .req        (req),
    .fill_we    (fill_we),
    .fill_index (fill_index),
    .fill_tag   (fill_tag),
    .dec        (dec)
  );

  cache_execute u_execute (
    .cpu_intf   (cpu_intf),
    .arst_n     (arst_n),
    .dec        (dec),
    .mem_valid  (mem_valid),
    .mem_rdata  (mem_rdata),
    .busy       (busy),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .fill_we    (fill_we),
    .fill_index (fill_index),
    .fill_tag   (fill_tag),
    .rsp        (rsp)
  );

  cache_result u_result (
    .cpu_intf   (cpu_intf),
    .arst_n     (arst_n),
    .rsp        (rsp),
    .rsp_valid  (rsp_valid),
    .rsp_hit    (rsp_hit),
    .rsp_data   (rsp_data),
    .hit_count  (hit_count),
    .miss_count (miss_count)
  );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic cpu_intf,
  output logic arst_n
);

  // 4 ns period
  initial begin
    cpu_intf = 1'b0;
    forever begin
      #2 cpu_intf = ~cpu_intf;
    end
  end

  // reset held for 10 clocks, released away from the rising edge
  initial begin
    arst_n = 1'b0;
    repeat (10) @(posedge cpu_intf);
    @(negedge cpu_intf);
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module tb_checker (
  input  wire logic            cpu_intf,
  input  wire logic            arst_n,
  input  wire ahb_pkg::haddr_t addr_in,
  input  wire logic            addr_push,
  input  wire logic            addr_full,
  input  wire ahb_pkg::hdata_t exp_word,
  input  wire logic            rsp_valid,
  input  wire logic            rsp_hit,
  input  wire ahb_pkg::hdata_t rsp_data,
  input  wire logic [15:0]     hit_count,
  input  wire logic [15:0]     miss_count,
  input  wire logic            mem_req,
  input  wire ahb_pkg::haddr_t mem_addr,
  input  wire logic            test_done,
  input  wire logic [7:0]      test_id,
  input  wire logic            test_missing,
  input  wire logic [3:0]      exp_drops,
  input  wire logic            stats_check,
  output int                   pending,
  output int                   pass_count,
  output int                   fail_count
);

  // reference direct-mapped store
  cache_pkg::tag_t         model_tag [`CACHE_LINES];
  ahb_pkg::hdata_t         model_data [`CACHE_LINES];
  logic [`CACHE_LINES-1:0] model_valid = '0;
  // {hit, data} per accepted read in issue order
  logic [`DATA_W:0]        exp_q [$];
  // addresses of accepted misses in issue order
  ahb_pkg::haddr_t         miss_q [$];
  int                      test_errs = 0;
  int                      drop_cnt = 0;
  int                      model_hits = 0;
  int                      model_misses = 0;
  int                      reset_cycles = 0;

  initial begin
    pass_count = 0;
    fail_count = 0;
    pending    = 0;
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic report_test(input string label);
    if (test_errs == 0) begin
      $display("%s: pass", label);
      pass_count++;
    end else begin
      $display("%s: fail, %0d error(s)", label, test_errs);
      fail_count++;
    end
    test_errs = 0;
  endtask

  always @(posedge cpu_intf) begin : watch
    cache_pkg::index_t idx;
    cache_pkg::tag_t   tag;
    logic              hit;
    logic [`DATA_W:0]  head;
    // quiet outputs during reset and just after
    if (!arst_n || reset_cycles < 2) begin
      compare_value("rsp_valid", 32'(rsp_valid), 32'h0);
      compare_value("mem_req", 32'(mem_req), 32'h0);
      compare_value("addr_full", 32'(addr_full), 32'h0);
      compare_value("hit_count", 32'(hit_count), 32'h0);
      compare_value("miss_count", 32'(miss_count), 32'h0);
      if (arst_n) begin
        reset_cycles++;
      end
    end
    // a push seen while full never enters the queue
    if (arst_n && addr_push) begin
      if (addr_full) begin
        drop_cnt++;
      end else begin
        idx = addr_in[`INDEX_W+1:2];
        tag = addr_in[`ADDR_W-1:`INDEX_W+2];
        hit = model_valid[idx] && (model_tag[idx] == tag);
        if (hit) begin
          exp_q.push_back({1'b1, model_data[idx]});
          model_hits++;
        end else begin
          exp_q.push_back({1'b0, exp_word});
          miss_q.push_back(addr_in);
          model_tag[idx]   = tag;
          model_data[idx]  = exp_word;
          model_valid[idx] = 1'b1;
          model_misses++;
        end
      end
    end
    // each memory request fetches the oldest outstanding miss
    if (arst_n && mem_req) begin
      if (miss_q.size() == 0) begin
        $display("test %0d: memory request with no miss pending", test_id);
        test_errs++;
      end else begin
        compare_value("mem_addr", mem_addr, miss_q.pop_front());
      end
    end
    if (arst_n && rsp_valid) begin
      if (exp_q.size() == 0) begin
        $display("test %0d: response arrived with no read pending", test_id);
        test_errs++;
      end else begin
        head = exp_q.pop_front();
        compare_value("rsp_hit", 32'(rsp_hit), 32'(head[`DATA_W]));
        compare_value("rsp_data", rsp_data, head[`DATA_W-1:0]);
      end
    end
    if (test_done) begin
      if (test_missing) begin
        $display("test %0d: %0d response(s) never arrived", test_id, exp_q.size());
        test_errs++;
      end
      if (drop_cnt != int'(exp_drops)) begin
        $display("test %0d: %0d push(es) dropped where %0d were expected",
                 test_id, drop_cnt, exp_drops);
        test_errs++;
      end
      report_test($sformatf("test %0d", test_id));
      exp_q.delete();
      miss_q.delete();
      drop_cnt = 0;
    end
    // counters against the model's tally
    if (stats_check) begin
      compare_value("hit_count", 32'(hit_count), model_hits);
      compare_value("miss_count", 32'(miss_count), model_misses);
      report_test("stats");
    end
    pending = exp_q.size();
  end

endmodule

`default_nettype wire

/* tb_cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module tb_cache_top;

  localparam int MAX_RECS = 64;
  // test number of the queue overflow burst
  localparam int BP_TEST = 4;

  logic            cpu_intf;
  logic            arst_n;
  ahb_pkg::haddr_t addr_in = '0;
  logic            addr_push = 1'b0;
  logic            addr_full;
  logic            mem_req;
  ahb_pkg::haddr_t mem_addr;
  logic            mem_valid = 1'b0;
  ahb_pkg::hdata_t mem_rdata = '0;
  logic            rsp_valid;
  logic            rsp_hit;
  ahb_pkg::hdata_t rsp_data;
  logic [15:0]     hit_count;
  logic [15:0]     miss_count;
  ahb_pkg::hdata_t exp_word = '0;
  logic            test_done = 1'b0;
  logic [7:0]      test_id = '0;
  logic            test_missing = 1'b0;
  logic [3:0]      exp_drops = '0;
  logic            stats_check = 1'b0;
  int              pending;
  int              pass_count;
  int              fail_count;

  // three words per record for test number, address and memory word
  logic [31:0] stim_words [0:3*MAX_RECS-1];
  int          rec_count = 0;
  // memory model state
  integer      seed = 34614;
  logic        mem_busy = 1'b0;
  int          mem_wait = 0;
  ahb_pkg::hdata_t mem_word = '0;

  tb_clock_gen u_clock_gen (
    .cpu_intf (cpu_intf),
    .arst_n   (arst_n)
  );

  cache_top u_cache_top (
    .cpu_intf   (cpu_intf),
    .arst_n     (arst_n),
    .addr_in    (addr_in),
    .addr_push  (addr_push),
    .addr_full  (addr_full),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .mem_valid  (mem_valid),
    .mem_rdata  (mem_rdata),
    .rsp_valid  (rsp_valid),
    .rsp_hit    (rsp_hit),
    .rsp_data   (rsp_data),
    .hit_count  (hit_count),
    .miss_count (miss_count)
  );

  tb_checker u_checker (
    .cpu_intf     (cpu_intf),
    .arst_n       (arst_n),
    .addr_in      (addr_in),
    .addr_push    (addr_push),
    .addr_full    (addr_full),
    .exp_word     (exp_word),
    .rsp_valid    (rsp_valid),
    .rsp_hit      (rsp_hit),
    .rsp_data     (rsp_data),
    .hit_count    (hit_count),
    .miss_count   (miss_count),
    .mem_req      (mem_req),
    .mem_addr     (mem_addr),
    .test_done    (test_done),
    .test_id      (test_id),
    .test_missing (test_missing),
    .exp_drops    (exp_drops),
    .stats_check  (stats_check),
    .pending      (pending),
    .pass_count   (pass_count),
    .fail_count   (fail_count)
  );

  // each address has one fixed word in the stim file
  function automatic ahb_pkg::hdata_t memory_word(input ahb_pkg::haddr_t a);
    for (int k = 0; k < rec_count; k++) begin
      if (stim_words[3*k+1] == a) begin
        return stim_words[3*k+2];
      end
    end
    return 32'hdeadbeef;
  endfunction

  // memory answers 1 to 8 cycles after the request
  always @(negedge cpu_intf) begin
    mem_valid <= 1'b0;
    if (mem_busy) begin
      if (mem_wait <= 1) begin
        mem_valid <= 1'b1;
        mem_rdata <= mem_word;
        mem_busy  <= 1'b0;
      end else begin
        mem_wait <= mem_wait - 1;
      end
    end else if (mem_req) begin
      mem_busy <= 1'b1;
      mem_wait <= 1 + int'($unsigned($random(seed)) % 32'd8);
      mem_word <= memory_word(mem_addr);
    end
  end

  // one record onto the address queue with an optional wait for room
  task automatic push_record(input int r, input logic wait_room);
    @(negedge cpu_intf);
    if (wait_room) begin
      while (addr_full) begin
        addr_push = 1'b0;
        @(negedge cpu_intf);
      end
    end
    addr_in   = stim_words[3*r+1];
    exp_word  = stim_words[3*r+2];
    addr_push = 1'b1;
  endtask

  task automatic finish_test(input int id, input logic missing, input int drops);
    @(negedge cpu_intf);
    test_id      = 8'(id);
    test_missing = missing;
    exp_drops    = 4'(drops);
    test_done    = 1'b1;
    @(negedge cpu_intf);
    test_done    = 1'b0;
    test_missing = 1'b0;
    exp_drops    = '0;
  endtask

  // run limit from the record count plus reset
  initial begin
    wait (rec_count > 0);
    #(rec_count * (`REQ_PERIOD + 12) * 4 + 10 * 4);
    $display("watchdog expired at %0t, the tests did not complete", $time);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : main
    int   i;
    int   last;
    int   tid;
    int   wait_cycles;
    logic missing;
    for (i = 0; i < 3 * MAX_RECS; i++) begin
      stim_words[i] = '0;
    end
    $readmemh("cache_stim.txt", stim_words);
    // a zero test number ends the list
    while (rec_count < MAX_RECS && stim_words[3*rec_count] != 0) begin
      rec_count++;
    end
    if (rec_count == 0) begin
      $display("no records found in cache_stim.txt");
      $display("TEST FAILED");
      $finish;
    end else begin
      wait (arst_n === 1'b1);
      repeat (3) @(negedge cpu_intf);
      // test 0 covers the reset state
      finish_test(0, 1'b0, 0);
      i = 0;
      while (i < rec_count) begin
        tid  = stim_words[3*i];
        last = i;
        while (last + 1 < rec_count && stim_words[3*(last+1)] == tid) begin
          last++;
        end
        missing = 1'b0;
        if (tid == BP_TEST) begin
          // first read misses and the queue fills while the cache is busy
          push_record(i, 1'b1);
          @(negedge cpu_intf);
          addr_push   = 1'b0;
          wait_cycles = 0;
          while (!mem_req && wait_cycles < 3 * `REQ_PERIOD) begin
            @(negedge cpu_intf);
            wait_cycles++;
          end
          if (!mem_req) begin
            $display("test %0d: no memory request for the first read", tid);
            missing = 1'b1;
          end
          for (int j = i + 1; j <= last; j++) begin
            push_record(j, 1'b0);
          end
        end else begin
          for (int j = i; j <= last; j++) begin
            push_record(j, 1'b1);
          end
        end
        @(negedge cpu_intf);
        addr_push = 1'b0;
        @(negedge cpu_intf);
        wait_cycles = 0;
        while (pending != 0 && wait_cycles < (last - i + 1) * (`REQ_PERIOD + 12)) begin
          @(negedge cpu_intf);
          wait_cycles++;
        end
        if (pending != 0) begin
          missing = 1'b1;
        end
        finish_test(tid, missing, (tid == BP_TEST) ? 1 : 0);
        i = last + 1;
      end
      @(negedge cpu_intf);
      stats_check = 1'b1;
      @(negedge cpu_intf);
      stats_check = 1'b0;
      @(negedge cpu_intf);
      $display("tests passed %0d failed %0d", pass_count, fail_count);
      if (fail_count == 0) begin
        $display("TEST OK");
      end else begin
        $display("TEST FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* cache_stim.txt */
// columns: test number, address, memory word (hex)
// test 4 pushes its last five back to back, the final one is dropped
01 00000000 3c0a1f00
01 00000004 3c0a1f04
01 00000008 5a17c308
01 0000000c 9e2b440c
01 00000010 d1e0aa10
02 00000000 3c0a1f00
02 00000004 3c0a1f04
02 00000008 5a17c308
02 0000000c 9e2b440c
02 00000010 d1e0aa10
03 10000018 71000018
03 20000018 72000018
03 10000018 71000018
03 20000018 72000018
03 10000018 71000018
03 20000018 72000018
04 00000100 0b0b0100
04 00000020 c0de0020
04 00000024 c0de0024
04 00000028 c0de0028
04 0000002c c0de002c
04 00000030 c0de0030
05 00000020 c0de0020
05 00000000 3c0a1f00
05 00000100 0b0b0100
05 00000030 c0de0030
05 00000030 c0de0030
05 10000018 71000018
05 00000004 3c0a1f04
05 00000024 c0de0024

/* project.f */
+incdir+.
ahb_pkg.sv
cache_pkg.sv
cpu_req_pacer.sv
cache_decode.sv
cache_execute.sv
cache_result.sv
cache_top.sv
tb_clock_gen.sv
tb_checker.sv
tb_cache_top.sv

/* run.sh */
#!/bin/sh
# build and run with Verilator, verdict from the simulation log
verilator --binary --timing -f project.f --top-module tb_cache_top -o sim_cache > build.log 2>&1 \
  && ./obj_dir/sim_cache > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
